// File: compile.f
verilog/bp_cfg_pkg.sv
verilog/bp_counter_pkg.sv
verilog/pred_table.sv
verilog/fetch_lookup.sv
verilog/branch_resolver.sv
verilog/branch_predictor.sv
verification/branch_predictor_asserts.sv
verification/branch_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the branch predictor testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module branch_predictor_tb -f compile.f \
    -o sim_bp || { echo "build failed"; exit 1; }
./obj_dir/sim_bp > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"
exit 0

// File: verification/branch_predictor_asserts.sv
// protocol and reset checks bound onto the branch predictor top level
// output strobes stay low in reset and follow their requests by one cycle
`timescale 1ns/1ns

module branch_predictor_asserts (
    input logic clk,
    input logic rst,
    input logic fetch_valid,
    input logic res_valid,
    input logic pred_valid,
    input logic pred_taken,
    input logic mispredict
);

    // nothing leaves the predictor while reset is held
    reset_quiet: assert property (@(posedge clk) rst |-> !pred_valid && !pred_taken && !mispredict)
        else $error("output strobe active during reset");

    // prediction latency fixed at one cycle
    pred_after_fetch: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |=> pred_valid)
        else $error("pred_valid missing one cycle after fetch_valid");
    pred_only_after_fetch: assert property (@(posedge clk) disable iff (rst)
        !fetch_valid |=> !pred_valid)
        else $error("pred_valid without a fetch one cycle earlier");
    taken_within_pred: assert property (@(posedge clk) disable iff (rst)
        pred_taken |-> pred_valid)
        else $error("pred_taken raised outside a prediction");

    // mispredict only ever one cycle behind a resolve
    misp_only_after_res: assert property (@(posedge clk) disable iff (rst)
        !res_valid |=> !mispredict)
        else $error("mispredict without a resolve one cycle earlier");

endmodule

bind branch_predictor branch_predictor_asserts i_branch_predictor_asserts (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .res_valid   (res_valid),
    .pred_valid  (pred_valid),
    .pred_taken  (pred_taken),
    .mispredict  (mispredict)
);

// File: verification/branch_predictor_tb.sv
// testbench for the branch predictor top level
// drives fetch and resolve strobes, mirrors both tables in a behavioural model
// and checks every prediction and redirect with concurrent assertions
`timescale 1ns/1ns

module branch_predictor_tb;

    localparam int PC_W      = bp_cfg_pkg::PC_W;
    localparam int BHT_BITS  = bp_cfg_pkg::BHT_INDEX_BITS_DEF;
    localparam int BTB_BITS  = bp_cfg_pkg::BTB_INDEX_BITS_DEF;
    localparam int TAG_W     = PC_W - BTB_BITS - 2;  // pc bits above the btb index
    localparam int MIX_OPS   = 300;
    localparam int TOTAL_OPS = MIX_OPS + 80;         // directed tests fit in 80 cycles

    typedef logic [PC_W-1:0] pc_t;

    logic clk;
    logic rst;
    logic fetch_valid;
    pc_t  fetch_pc;
    logic res_valid;
    pc_t  res_pc;
    logic res_taken;
    pc_t  res_target;
    logic res_pred_taken;
    pc_t  res_pred_target;
    logic pred_valid;
    logic pred_taken;
    pc_t  pred_target;
    logic mispredict;
    pc_t  redirect_pc;

    // reference model state
    logic             m_bht_valid [2**BHT_BITS];
    logic [1:0]       m_ctr [2**BHT_BITS];       // 3 strong taken .. 0 strong not-taken
    logic             m_btb_valid [2**BTB_BITS];
    logic [TAG_W-1:0] m_btb_tag [2**BTB_BITS];
    pc_t              m_btb_target [2**BTB_BITS];

    // expected values for the cycle being driven, and one cycle later
    logic exp_taken;
    pc_t  exp_target;
    logic exp_misp;
    pc_t  exp_redirect;
    logic exp_taken_q;
    pc_t  exp_target_q;
    logic exp_misp_q;
    pc_t  exp_redirect_q;

    logic [15:0] lfsr;
    logic [31:0] rnd;
    int          err_count = 0;
    int          err_start;
    int          n_pass = 0;
    int          n_fail = 0;

    branch_predictor i_branch_predictor (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // run time bound, reset plus every test cycle with a margin of 4
    initial begin
        #((TOTAL_OPS + 4) * 4 * 4);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, taps 16 14 13 11
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);  // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // small pc pool, 4 word slots times 4 tags, so slots collide often
    function automatic pc_t pool_pc(logic [3:0] k);
        return 32'h0000_1000 + (32'(k[3:2]) << 16) + (32'(k[1:0]) << 2);
    endfunction

    function automatic logic model_taken(pc_t pc);
        logic [BHT_BITS-1:0] bi;
        logic [BTB_BITS-1:0] ti;
        bi = pc[2 +: BHT_BITS];
        ti = pc[2 +: BTB_BITS];
        return m_bht_valid[bi] && m_ctr[bi][1] && m_btb_valid[ti]
               && (m_btb_tag[ti] == pc[PC_W-1 -: TAG_W]);
    endfunction

    task automatic model_train(pc_t pc, logic taken, pc_t target);
        logic [BHT_BITS-1:0] bi;
        logic [BTB_BITS-1:0] ti;
        bi = pc[2 +: BHT_BITS];
        ti = pc[2 +: BTB_BITS];
        if (!m_bht_valid[bi]) begin
            m_ctr[bi] = taken ? 2'd2 : 2'd1;  // first sight, weak on the outcome side
        end else if (taken && m_ctr[bi] != 2'd3) begin
            m_ctr[bi] = m_ctr[bi] + 2'd1;
        end else if (!taken && m_ctr[bi] != 2'd0) begin
            m_ctr[bi] = m_ctr[bi] - 2'd1;
        end
        m_bht_valid[bi] = 1'b1;
        if (taken) begin  // btb learns taken targets only
            m_btb_valid[ti]  = 1'b1;
            m_btb_tag[ti]    = pc[PC_W-1 -: TAG_W];
            m_btb_target[ti] = target;
        end
    endtask

    // one cycle of stimulus, fetch sees the model before this cycle's training
    task automatic do_cycle(input logic fv, input pc_t fpc, input logic rv, input pc_t rpc,
                            input logic rt, input pc_t rtgt, input logic rpt, input pc_t rptgt);
        fetch_valid     = fv;
        fetch_pc        = fpc;
        res_valid       = rv;
        res_pc          = rpc;
        res_taken       = rt;
        res_target      = rtgt;
        res_pred_taken  = rpt;
        res_pred_target = rptgt;
        exp_taken       = model_taken(fpc);
        exp_target      = exp_taken ? m_btb_target[fpc[2 +: BTB_BITS]] : fpc + 32'd4;
        exp_misp        = (rt != rpt) || (rt && rpt && (rtgt != rptgt));
        exp_redirect    = rt ? rtgt : rpc + 32'd4;
        if (rv) begin
            model_train(rpc, rt, rtgt);
        end
        @(posedge clk);
        #1;  // next drive point
    endtask

    task automatic fetch(pc_t pc);
        do_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic resolve(pc_t pc, logic t, pc_t tgt, logic pt, pc_t ptgt);
        do_cycle(1'b0, '0, 1'b1, pc, t, tgt, pt, ptgt);
    endtask

    task automatic idle();
        do_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic end_test(string name);
        idle();
        idle();  // let the last checks fire
        if (err_count == err_start) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, err_count - err_start);
        end
        err_start = err_count;
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        err_count++;
        $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    endtask

    // model outputs delayed like the dut registers
    always @(posedge clk) begin
        if (fetch_valid) begin
            exp_taken_q  <= exp_taken;
            exp_target_q <= exp_target;
        end
        if (res_valid) begin
            exp_misp_q     <= exp_misp;
            exp_redirect_q <= exp_redirect;
        end
    end

    chk_pred_taken: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |=> pred_taken == exp_taken_q)
        else report_mismatch("pred_taken", 32'($sampled(pred_taken)), 32'($sampled(exp_taken_q)));
    chk_pred_target: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |=> pred_target == exp_target_q)
        else report_mismatch("pred_target", $sampled(pred_target), $sampled(exp_target_q));
    chk_mispredict: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> mispredict == exp_misp_q)
        else report_mismatch("mispredict", 32'($sampled(mispredict)), 32'($sampled(exp_misp_q)));
    chk_redirect: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> redirect_pc == exp_redirect_q)
        else report_mismatch("redirect_pc", $sampled(redirect_pc), $sampled(exp_redirect_q));

    initial begin
        rst             = 1'b1;
        fetch_valid     = 1'b0;
        fetch_pc        = '0;
        res_valid       = 1'b0;
        res_pc          = '0;
        res_taken       = 1'b0;
        res_target      = '0;
        res_pred_taken  = 1'b0;
        res_pred_target = '0;
        lfsr            = 16'd37;  // seed
        for (int i = 0; i < 2**BHT_BITS; i++) begin
            m_bht_valid[i] = 1'b0;
        end
        for (int i = 0; i < 2**BTB_BITS; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        err_start = err_count;

        for (int i = 0; i < 4; i++) begin  // cold tables, any pc falls through
            take_bits(30, rnd);
            fetch({rnd[29:0], 2'b00});
        end
        end_test("reset and cold fetch");

        resolve(32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, '0);  // allocate weak taken
        fetch(32'h0000_1040);
        resolve(32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000);
        resolve(32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000);  // saturated
        resolve(32'h0000_1040, 1'b0, 32'h0000_2000, 1'b1, 32'h0000_2000);
        fetch(32'h0000_1040);  // still leaning taken
        resolve(32'h0000_1040, 1'b0, 32'h0000_2000, 1'b1, 32'h0000_2000);
        fetch(32'h0000_1040);  // now not-taken
        end_test("counter training");

        resolve(32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, '0);
        resolve(32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000);
        fetch(32'h0000_1040);
        fetch(32'h0001_1040);  // same slots, other tag
        end_test("btb tag check");

        resolve(32'h0000_3000, 1'b1, 32'h0000_4000, 1'b0, '0);             // wrong direction
        resolve(32'h0000_3000, 1'b0, 32'h0000_4000, 1'b1, 32'h0000_4000);  // wrong direction
        resolve(32'h0000_3000, 1'b1, 32'h0000_4000, 1'b1, 32'h0000_4010);  // wrong target
        resolve(32'h0000_3000, 1'b1, 32'h0000_4000, 1'b1, 32'h0000_4000);  // correct
        resolve(32'h0000_3000, 1'b0, 32'h0000_4000, 1'b0, '0);             // correct
        end_test("mispredict");

        for (int i = 0; i < MIX_OPS; i++) begin
            take_bits(16, rnd);
            do_cycle(rnd[0], pool_pc(rnd[5:2]), rnd[1], pool_pc({1'b0, rnd[8:6]}), rnd[9],
                     32'h0000_8000 + (32'(rnd[11:10]) << 4), rnd[12],
                     32'h0000_8000 + (32'(rnd[14:13]) << 4));
        end
        end_test("mixed stream");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/bp_cfg_pkg.sv
// geometry of the branch predictor tables and the pc
// used by the fetch and resolve stages and by the top level
package bp_cfg_pkg;

    // pc and instruction size
    parameter int PC_W       = 32;  // one word
    parameter int INSN_BYTES = 4;   // fixed-length instructions

    // byte offset bits below the word address are dropped before indexing
    parameter int IDX_LSB = $clog2(INSN_BYTES);

    // fall-through increment at full pc width
    parameter logic [PC_W-1:0] PC_INC = PC_W'(INSN_BYTES);

    // default table geometry that the top level can override
    parameter int BHT_INDEX_BITS_DEF = 8;  // 256 counters
    parameter int BTB_INDEX_BITS_DEF = 6;  // 64 targets

    // the BTB tag is what is left of the pc above the index
    // and is derived where BTB_INDEX_BITS is known

endpackage

// File: verilog/bp_counter_pkg.sv
// 2-bit saturating counter used in the branch history table
// state encoding and the next-state functions for training and allocation
package bp_counter_pkg;

    typedef logic [1:0] ctr_t;

    // top bit set means predict taken
    parameter ctr_t CTR_STRONG_T = 2'b11;
    parameter ctr_t CTR_WEAK_T   = 2'b10;
    parameter ctr_t CTR_WEAK_N   = 2'b01;
    parameter ctr_t CTR_STRONG_N = 2'b00;

    // saturating move toward the outcome
    function automatic ctr_t ctr_step(ctr_t ctr, logic taken);
        ctr_t nxt;
        nxt = ctr;
        if (taken && ctr != CTR_STRONG_T) begin
            nxt = ctr + 2'd1;  // count up
        end else if (!taken && ctr != CTR_STRONG_N) begin
            nxt = ctr - 2'd1;  // count down
        end
        return nxt;
    endfunction

    // first sighting of a branch, start weak on the observed side
    function automatic ctr_t ctr_alloc(logic taken);
        return taken ? CTR_WEAK_T : CTR_WEAK_N;
    endfunction

    // direction read out of a counter
    function automatic logic ctr_taken(ctr_t ctr);
        return ctr[1];
    endfunction

endpackage

// File: verilog/branch_predictor.sv
// branch predictor top level for the fetch stage
// BHT and BTB tables, fetch-side lookup and resolve-side training
// fetch to prediction, resolve to mispredict and resolve to visible training all take 1 cycle
`timescale 1ns/1ns

module branch_predictor #(
    parameter int BHT_INDEX_BITS = bp_cfg_pkg::BHT_INDEX_BITS_DEF,
    parameter int BTB_INDEX_BITS = bp_cfg_pkg::BTB_INDEX_BITS_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    // fetch strobe
    input  logic                          fetch_valid,
    input  logic [bp_cfg_pkg::PC_W-1:0]   fetch_pc,
    // resolve strobe
    input  logic                          res_valid,
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_pc,
    input  logic                          res_taken,
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_target,
    input  logic                          res_pred_taken,
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_pred_target,
    // prediction
    output logic                          pred_valid,
    output logic                          pred_taken,
    output logic [bp_cfg_pkg::PC_W-1:0]   pred_target,
    // redirect
    output logic                          mispredict,
    output logic [bp_cfg_pkg::PC_W-1:0]   redirect_pc
);

    // pc bits above the btb index
    localparam int TAG_W = bp_cfg_pkg::PC_W - BTB_INDEX_BITS - bp_cfg_pkg::IDX_LSB;

    typedef struct packed {
        logic [TAG_W-1:0]            tag;
        logic [bp_cfg_pkg::PC_W-1:0] target;
    } btb_entry_t;

    // BHT wiring
    logic [BHT_INDEX_BITS-1:0]   bht_rd_a_index;
    logic                        bht_rd_a_valid;
    bp_counter_pkg::ctr_t        bht_rd_a_ctr;
    logic [BHT_INDEX_BITS-1:0]   bht_rd_b_index;
    logic                        bht_rd_b_valid;
    bp_counter_pkg::ctr_t        bht_rd_b_ctr;
    logic                        bht_wr_en;
    logic [BHT_INDEX_BITS-1:0]   bht_wr_index;
    bp_counter_pkg::ctr_t        bht_wr_ctr;

    // BTB wiring
    logic [BTB_INDEX_BITS-1:0]   btb_rd_index;
    logic                        btb_rd_valid;
    btb_entry_t                  btb_rd_entry;
    logic                        btb_wr_en;
    logic [BTB_INDEX_BITS-1:0]   btb_wr_index;
    logic [TAG_W-1:0]            btb_wr_tag;
    logic [bp_cfg_pkg::PC_W-1:0] btb_wr_target;

    pred_table #(
        .INDEX_BITS (BHT_INDEX_BITS),
        .payload_t  (bp_counter_pkg::ctr_t)
    ) i_bht (
        .clk        (clk),
        .rst        (rst),
        .rd_a_index (bht_rd_a_index),  // fetch
        .rd_a_valid (bht_rd_a_valid),
        .rd_a_data  (bht_rd_a_ctr),
        .rd_b_index (bht_rd_b_index),  // resolve
        .rd_b_valid (bht_rd_b_valid),
        .rd_b_data  (bht_rd_b_ctr),
        .wr_en      (bht_wr_en),
        .wr_index   (bht_wr_index),
        .wr_data    (bht_wr_ctr)
    );

    pred_table #(
        .INDEX_BITS (BTB_INDEX_BITS),
        .payload_t  (btb_entry_t)
    ) i_btb (
        .clk        (clk),
        .rst        (rst),
        .rd_a_index (btb_rd_index),
        .rd_a_valid (btb_rd_valid),
        .rd_a_data  (btb_rd_entry),
        .rd_b_index ('0),              // second port idle on the btb
        .rd_b_valid (),
        .rd_b_data  (),
        .wr_en      (btb_wr_en),
        .wr_index   (btb_wr_index),
        .wr_data    ({btb_wr_tag, btb_wr_target})  // packs as tag then target
    );

    fetch_lookup #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .BTB_INDEX_BITS (BTB_INDEX_BITS),
        .TAG_W          (TAG_W)
    ) i_fetch_lookup (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .bht_index   (bht_rd_a_index),
        .btb_index   (btb_rd_index),
        .bht_valid   (bht_rd_a_valid),
        .bht_ctr     (bht_rd_a_ctr),
        .btb_valid   (btb_rd_valid),
        .btb_tag     (btb_rd_entry.tag),
        .btb_target  (btb_rd_entry.target),
        .pred_valid  (pred_valid),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    branch_resolver #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS),
        .BTB_INDEX_BITS (BTB_INDEX_BITS),
        .TAG_W          (TAG_W)
    ) i_branch_resolver (
        .clk             (clk),
        .rst             (rst),
        .res_valid       (res_valid),
        .res_pc          (res_pc),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_pred_taken  (res_pred_taken),
        .res_pred_target (res_pred_target),
        .bht_rd_index    (bht_rd_b_index),
        .bht_rd_valid    (bht_rd_b_valid),
        .bht_rd_ctr      (bht_rd_b_ctr),
        .bht_wr_en       (bht_wr_en),
        .bht_wr_index    (bht_wr_index),
        .bht_wr_ctr      (bht_wr_ctr),
        .btb_wr_en       (btb_wr_en),
        .btb_wr_index    (btb_wr_index),
        .btb_wr_tag      (btb_wr_tag),
        .btb_wr_target   (btb_wr_target),
        .mispredict      (mispredict),
        .redirect_pc     (redirect_pc)
    );

endmodule

// File: verilog/branch_resolver.sv
// resolve-side training unit
// a branch retiring from execute updates the BHT counter and, when taken, the BTB entry
// the misprediction decision and redirect pc come out one cycle later
`timescale 1ns/1ns

module branch_resolver #(
    parameter int BHT_INDEX_BITS = 8,
    parameter int BTB_INDEX_BITS = 6,
    parameter int TAG_W          = 24
) (
    input  logic                          clk,
    input  logic                          rst,
    // resolve strobe from execute
    input  logic                          res_valid,
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_pc,
    input  logic                          res_taken,
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_target,
    input  logic                          res_pred_taken,   // carried from fetch
    input  logic [bp_cfg_pkg::PC_W-1:0]   res_pred_target,
    // BHT read port b
    output logic [BHT_INDEX_BITS-1:0]     bht_rd_index,
    input  logic                          bht_rd_valid,
    input  bp_counter_pkg::ctr_t          bht_rd_ctr,
    // BHT write port
    output logic                          bht_wr_en,
    output logic [BHT_INDEX_BITS-1:0]     bht_wr_index,
    output bp_counter_pkg::ctr_t          bht_wr_ctr,
    // BTB write port
    output logic                          btb_wr_en,
    output logic [BTB_INDEX_BITS-1:0]     btb_wr_index,
    output logic [TAG_W-1:0]              btb_wr_tag,
    output logic [bp_cfg_pkg::PC_W-1:0]   btb_wr_target,
    // redirect to fetch
    output logic                          mispredict,
    output logic [bp_cfg_pkg::PC_W-1:0]   redirect_pc
);

    logic                        dir_wrong;
    logic                        tgt_wrong;
    logic                        mispredict_c;
    logic [bp_cfg_pkg::PC_W-1:0] redirect_c;

    // current counter for the retiring branch
    assign bht_rd_index = res_pc[bp_cfg_pkg::IDX_LSB +: BHT_INDEX_BITS];

    // counter update, write lands at the end of this cycle
    assign bht_wr_en    = res_valid;
    assign bht_wr_index = bht_rd_index;  // same slot as the read
    assign bht_wr_ctr   = bht_rd_valid ? bp_counter_pkg::ctr_step(bht_rd_ctr, res_taken)
                                       : bp_counter_pkg::ctr_alloc(res_taken);  // first sight

    // btb only learns taken targets
    assign btb_wr_en     = res_valid && res_taken;
    assign btb_wr_index  = res_pc[bp_cfg_pkg::IDX_LSB +: BTB_INDEX_BITS];
    assign btb_wr_tag    = res_pc[bp_cfg_pkg::PC_W-1 -: TAG_W];
    assign btb_wr_target = res_target;

    // wrong direction, or taken both ways but to a different place
    assign dir_wrong    = res_taken != res_pred_taken;
    assign tgt_wrong    = res_taken && res_pred_taken && (res_target != res_pred_target);
    assign mispredict_c = res_valid && (dir_wrong || tgt_wrong);
    assign redirect_c   = res_taken ? res_target : res_pc + bp_cfg_pkg::PC_INC;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mispredict <= 1'b0;
        end else begin
            mispredict <= mispredict_c;  // one-cycle strobe
        end
    end

    // redirect pc only loaded by a resolve
    always_ff @(posedge clk) begin
        if (res_valid) begin
            redirect_pc <= redirect_c;
        end
    end

endmodule

// File: verilog/fetch_lookup.sv
// fetch-side lookup, turns the BHT and BTB reads for the fetch pc into a prediction
// drives the read-port-a indices of both tables and registers the result, latency 1
`timescale 1ns/1ns

module fetch_lookup #(
    parameter int BHT_INDEX_BITS = 8,
    parameter int BTB_INDEX_BITS = 6,
    parameter int TAG_W          = 24
) (
    input  logic                          clk,
    input  logic                          rst,
    // fetch strobe
    input  logic                          fetch_valid,
    input  logic [bp_cfg_pkg::PC_W-1:0]   fetch_pc,
    // table read addresses
    output logic [BHT_INDEX_BITS-1:0]     bht_index,
    output logic [BTB_INDEX_BITS-1:0]     btb_index,
    // table read data
    input  logic                          bht_valid,
    input  bp_counter_pkg::ctr_t          bht_ctr,
    input  logic                          btb_valid,
    input  logic [TAG_W-1:0]              btb_tag,
    input  logic [bp_cfg_pkg::PC_W-1:0]   btb_target,
    // registered prediction
    output logic                          pred_valid,
    output logic                          pred_taken,
    output logic [bp_cfg_pkg::PC_W-1:0]   pred_target
);

    logic                        btb_hit;
    logic                        taken_c;     // combinational direction
    logic [bp_cfg_pkg::PC_W-1:0] target_c;

    // word address slices, offset bits dropped
    assign bht_index = fetch_pc[bp_cfg_pkg::IDX_LSB +: BHT_INDEX_BITS];
    assign btb_index = fetch_pc[bp_cfg_pkg::IDX_LSB +: BTB_INDEX_BITS];

    // tag is everything above the btb index
    assign btb_hit = btb_valid && (btb_tag == fetch_pc[bp_cfg_pkg::PC_W-1 -: TAG_W]);

    // taken needs a valid counter leaning taken and a target to go to
    assign taken_c  = bht_valid && bp_counter_pkg::ctr_taken(bht_ctr) && btb_hit;
    assign target_c = taken_c ? btb_target : fetch_pc + bp_cfg_pkg::PC_INC;  // else fall through

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid <= 1'b0;
            pred_taken <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;              // one per fetch, no stall
            pred_taken <= fetch_valid && taken_c;   // low between predictions
        end
    end

    // target held until the next fetch
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pred_target <= target_c;
        end
    end

endmodule

// File: verilog/pred_table.sv
// direct-mapped predictor table with a valid bit per slot
// payload type is a parameter so one module serves as BHT and as BTB
// two combinational read ports, one write port at the clock edge
`timescale 1ns/1ns

module pred_table #(
    parameter int  INDEX_BITS = 8,
    parameter type payload_t  = logic [1:0]
) (
    input  logic                  clk,
    input  logic                  rst,
    // read port a
    input  logic [INDEX_BITS-1:0] rd_a_index,
    output logic                  rd_a_valid,
    output payload_t              rd_a_data,
    // read port b
    input  logic [INDEX_BITS-1:0] rd_b_index,
    output logic                  rd_b_valid,
    output payload_t              rd_b_data,
    // write port
    input  logic                  wr_en,
    input  logic [INDEX_BITS-1:0] wr_index,
    input  payload_t              wr_data
);

    localparam int SLOTS = 1 << INDEX_BITS;

    payload_t          mem [SLOTS];  // payload storage
    logic [SLOTS-1:0]  valid_q;      // slot holds a trained entry

    // valid bits, cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;  // any write validates the slot
        end
    end

    // payload array, contents only meaningful where valid
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // async reads, old value when writing the same slot this cycle
    assign rd_a_valid = valid_q[rd_a_index];
    assign rd_a_data  = mem[rd_a_index];
    assign rd_b_valid = valid_q[rd_b_index];
    assign rd_b_data  = mem[rd_b_index];

endmodule
